/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Serial bit timing shortened for simulation.
    localparam int clocks_per_bit = 16;
    localparam int half_bit = clocks_per_bit / 2;

    // Frame payload.
    localparam int payload_bits = 8;

    // Queue sizing shared by the transmit and receive queues.
    localparam int fifo_depth = 8;
    localparam int fifo_count_bits = $clog2(fifo_depth + 1);

    // Register selectors for address bits 4 to 2.
    localparam logic [2:0] reg_rx_full = 3'd4;
    localparam logic [2:0] reg_tx_empty = 3'd5;
    localparam logic [2:0] reg_rx_data = 3'd6;
    localparam logic [2:0] reg_rx_empty = 3'd3;

endpackage

`default_nettype wire

/* source/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input logic clk,
    input logic reset,
    input logic push,
    input logic pop,
    input logic [uart_pkg::payload_bits-1:0] push_data,
    output logic [uart_pkg::payload_bits-1:0] head,
    output logic full,
    output logic empty
);

    logic [uart_pkg::payload_bits-1:0] mem [uart_pkg::fifo_depth];
    logic [$clog2(uart_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(uart_pkg::fifo_depth)-1:0] rd_ptr;
    logic [uart_pkg::fifo_count_bits-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full; // Push into a full queue is lost.
    assign do_pop = pop && !empty;

    assign full = (count == ($bits(count))'(uart_pkg::fifo_depth));
    assign empty = (count == '0);
    assign head = mem[rd_ptr]; // First word falls through.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
    input logic clk,
    input logic reset,
    input logic start,
    input logic [uart_pkg::payload_bits-1:0] tx_byte,
    output logic busy,
    output logic tx
);

    // Start bit, payload and stop bit go out from bit 0 upward.
    logic [uart_pkg::payload_bits+1:0] frame;
    logic [$clog2(uart_pkg::clocks_per_bit)-1:0] bit_timer;
    logic [$clog2(uart_pkg::payload_bits+2)-1:0] bit_count;
    logic bit_done;

    assign tx = frame[0];
    assign bit_done = (bit_timer == ($bits(bit_timer))'(uart_pkg::clocks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            frame <= '1; // Line idles high.
            busy <= 1'b0;
            bit_timer <= '0;
            bit_count <= '0;
        end else if (!busy) begin
            if (start) begin
                frame <= {1'b1, tx_byte, 1'b0};
                busy <= 1'b1;
                bit_timer <= '0;
                bit_count <= '0;
            end
        end else begin
            if (bit_done) begin
                bit_timer <= '0;
                // Shifting in ones leaves the line high after the stop bit.
                frame <= {1'b1, frame[uart_pkg::payload_bits+1:1]};
                if (bit_count == ($bits(bit_count))'(uart_pkg::payload_bits + 1)) begin
                    busy <= 1'b0; // Stop bit finished.
                    bit_count <= '0;
                end else begin
                    bit_count <= bit_count + 1'b1;
                end
            end else begin
                bit_timer <= bit_timer + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
    input logic clk,
    input logic reset,
    input logic rx,
    output logic rx_valid,
    output logic [uart_pkg::payload_bits-1:0] rx_byte
);

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic [$clog2(uart_pkg::clocks_per_bit)-1:0] bit_timer;
    logic [$clog2(uart_pkg::payload_bits)-1:0] bit_index;
    logic half_done;
    logic bit_done;

    enum logic [1:0] {
        state_idle,
        state_start,
        state_data,
        state_stop
    } state;

    assign half_done = (bit_timer == ($bits(bit_timer))'(uart_pkg::half_bit - 1));
    assign bit_done = (bit_timer == ($bits(bit_timer))'(uart_pkg::clocks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1; // Idle line level.
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_idle;
            bit_timer <= '0;
            bit_index <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                state_idle: begin
                    bit_timer <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= state_start; // Falling edge.
                    end
                end
                state_start: begin
                    if (half_done) begin
                        bit_timer <= '0;
                        bit_index <= '0;
                        // A glitch has gone high again by mid-bit.
                        state <= rx_sync ? state_idle : state_data;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                state_data: begin
                    if (bit_done) begin
                        bit_timer <= '0;
                        rx_byte <= {rx_sync, rx_byte[uart_pkg::payload_bits-1:1]}; // LSB first.
                        if (bit_index == ($bits(bit_index))'(uart_pkg::payload_bits - 1)) begin
                            state <= state_stop;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        bit_timer <= '0;
                        rx_valid <= rx_sync; // Low stop bit drops the frame.
                        state <= state_idle;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/uart_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_periph (
    input logic clk,
    input logic reset,
    input logic rx,
    output logic tx,
    input logic read,
    input logic write,
    input logic [31:0] address,
    input logic [31:0] write_data,
    output logic response,
    output logic [31:0] read_data
);

    logic tx_push;
    logic tx_pop;
    logic tx_start;
    logic rx_push;
    logic rx_pop;
    logic [uart_pkg::payload_bits-1:0] tx_push_data;
    logic [uart_pkg::payload_bits-1:0] tx_byte;
    logic [uart_pkg::payload_bits-1:0] rx_push_data;
    logic [uart_pkg::payload_bits-1:0] tx_head;
    logic [uart_pkg::payload_bits-1:0] rx_head;
    logic [uart_pkg::payload_bits-1:0] rx_byte;
    logic tx_full;
    logic tx_empty;
    logic rx_full;
    logic rx_empty;
    logic tx_busy;
    logic rx_valid;
    logic data_select;

    assign response = read | write;

    // Status codes read a flag and every other code reads the receive head.
    assign data_select = (address[4:2] != uart_pkg::reg_rx_full)
                      && (address[4:2] != uart_pkg::reg_tx_empty)
                      && (address[4:2] != uart_pkg::reg_rx_empty);

    always_comb begin
        case (address[4:2])
            uart_pkg::reg_rx_full: read_data = {31'h0, rx_full};
            uart_pkg::reg_tx_empty: read_data = {31'h0, tx_empty};
            uart_pkg::reg_rx_empty: read_data = {31'h0, rx_empty};
            uart_pkg::reg_rx_data: read_data = {24'h0, rx_head};
            default: read_data = {24'h0, rx_head};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_push <= 1'b0;
            tx_pop <= 1'b0;
            tx_start <= 1'b0;
            rx_push <= 1'b0;
            rx_pop <= 1'b0;
        end else begin
            tx_push <= write && !tx_full;
            rx_pop <= read && data_select && !rx_empty;
            rx_push <= rx_valid && !rx_full; // Dropped when the queue is full.
            // No launch right after a start because busy has not risen yet.
            tx_start <= !tx_busy && !tx_empty && !tx_start;
            tx_pop <= !tx_busy && !tx_empty && !tx_start;
        end
    end

    always_ff @(posedge clk) begin
        tx_push_data <= write_data[uart_pkg::payload_bits-1:0];
        rx_push_data <= rx_byte;
        tx_byte <= tx_head;
    end

    byte_fifo tx_fifo (
        .clk(clk),
        .reset(reset),
        .push(tx_push),
        .pop(tx_pop),
        .push_data(tx_push_data),
        .head(tx_head),
        .full(tx_full),
        .empty(tx_empty)
    );

    byte_fifo rx_fifo (
        .clk(clk),
        .reset(reset),
        .push(rx_push),
        .pop(rx_pop),
        .push_data(rx_push_data),
        .head(rx_head),
        .full(rx_full),
        .empty(rx_empty)
    );

    uart_transmitter transmitter (
        .clk(clk),
        .reset(reset),
        .start(tx_start),
        .tx_byte(tx_byte),
        .busy(tx_busy),
        .tx(tx)
    );

    uart_receiver receiver (
        .clk(clk),
        .reset(reset),
        .rx(rx),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte)
    );

endmodule

`default_nettype wire

/* testbench/uart_periph_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_periph_tb;

    localparam int frame_bits = uart_pkg::payload_bits + 2;
    // Transmit, receive, overflow and stop-bit frames plus one frame of idle time.
    localparam int frames_total = uart_pkg::fifo_depth + 3 + (uart_pkg::fifo_depth + 2) + 2 + 1;
    localparam int watchdog_ns = 2 * frames_total * frame_bits * uart_pkg::clocks_per_bit * 20;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    logic read;
    logic write;
    logic [31:0] address;
    logic [31:0] write_data;
    logic response;
    logic [31:0] read_data;

    int errors;
    int test_errors;
    int tests_run;
    logic [7:0] tx_seen[$];
    logic [7:0] sent[$];

    uart_periph dut (
        .clk(clk),
        .reset(reset),
        .rx(rx),
        .tx(tx),
        .read(read),
        .write(write),
        .address(address),
        .write_data(write_data),
        .response(response),
        .read_data(read_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    response_follows_bus: assert property (@(posedge clk) response == (read || write))
        else begin
            errors++;
            $display("FAILED response: expected %h, got %h", read || write, response);
        end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic bus_write(input logic [7:0] data);
        @(negedge clk);
        read = 1'b0;
        write = 1'b1;
        address = 32'h0;
        write_data = {24'h0, data};
        @(posedge clk);
    endtask

    task automatic bus_release();
        @(negedge clk);
        read = 1'b0;
        write = 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] code, output logic [31:0] data);
        @(negedge clk);
        write = 1'b0;
        read = 1'b1;
        address = {27'h0, code, 2'b00};
        #5;
        data = read_data;
        @(negedge clk);
        read = 1'b0;
        @(negedge clk); // Registered pop lands here.
    endtask

    task automatic check_read(input logic [2:0] code, input string name,
                              input logic [31:0] expected);
        logic [31:0] data;
        bus_read(code, data);
        check_value(name, expected, data);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        logic [frame_bits-1:0] frame;
        frame = {stop_level, data, 1'b0};
        repeat (frame_bits) begin
            @(negedge clk);
            rx = frame[0];
            frame = frame >> 1;
            repeat (uart_pkg::clocks_per_bit - 1) @(negedge clk);
        end
        @(negedge clk);
        rx = 1'b1;
    endtask

    task automatic hold_rx_idle();
        rx = 1'b1;
        repeat (uart_pkg::clocks_per_bit) @(negedge clk);
    endtask

    task automatic wait_tx_frames(input int count);
        int cycles;
        int limit;
        cycles = 0;
        limit = count * frame_bits * uart_pkg::clocks_per_bit + 64;
        while (tx_seen.size() < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (tx_seen.size() >= count) else begin
            errors++;
            $display("The tx line carried only %0d of %0d frames in time.",
                     tx_seen.size(), count);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        test_errors = errors;
    endtask

    // Checks tx on every falling edge so a short or long bit shows up.
    initial begin : line_monitor
        logic [7:0] bits;
        forever begin
            @(negedge clk);
            if (!reset && tx === 1'b0) begin
                repeat (uart_pkg::clocks_per_bit - 1) begin
                    @(negedge clk);
                    check_value("tx start bit", 32'h0, {31'h0, tx});
                end
                repeat (uart_pkg::payload_bits) begin
                    @(negedge clk);
                    bits = {tx, bits[7:1]}; // LSB first.
                    repeat (uart_pkg::clocks_per_bit - 1) begin
                        @(negedge clk);
                        check_value("tx data bit", {31'h0, bits[7]}, {31'h0, tx});
                    end
                end
                repeat (uart_pkg::clocks_per_bit) begin
                    @(negedge clk);
                    check_value("tx stop bit", 32'h1, {31'h0, tx});
                end
                tx_seen.push_back(bits);
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("The watchdog expired before the tests finished.");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [7:0] value;
        void'($urandom(32'h5a4c));
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        reset = 1'b1;
        rx = 1'b1;
        read = 1'b0;
        write = 1'b0;
        address = 32'h0;
        write_data = 32'h0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        repeat (2 * uart_pkg::clocks_per_bit) begin
            @(negedge clk);
            check_value("tx", 32'h1, {31'h0, tx});
        end
        check_read(uart_pkg::reg_rx_empty, "rx_empty", 32'h1);
        check_read(uart_pkg::reg_tx_empty, "tx_empty", 32'h1);
        check_read(uart_pkg::reg_rx_full, "rx_full", 32'h0);
        report_test("reset state");

        for (int i = 0; i < uart_pkg::fifo_depth; i++) begin
            value = 8'($urandom());
            sent.push_back(value);
            bus_write(value);
        end
        bus_release();
        wait_tx_frames(uart_pkg::fifo_depth);
        foreach (sent[i]) begin
            check_value("tx byte", {24'h0, sent[i]}, {24'h0, tx_seen[i]});
        end
        check_read(uart_pkg::reg_tx_empty, "tx_empty", 32'h1);
        report_test("transmit");

        sent = {};
        repeat (3) begin
            value = 8'($urandom());
            sent.push_back(value);
            send_frame(value, 1'b1);
        end
        check_read(uart_pkg::reg_rx_empty, "rx_empty", 32'h0);
        check_read(uart_pkg::reg_rx_data, "rx_data", {24'h0, sent[0]});
        check_read(3'd7, "rx_data by default code", {24'h0, sent[1]});
        check_read(3'd1, "rx_data by default code", {24'h0, sent[2]});
        check_read(uart_pkg::reg_rx_empty, "rx_empty", 32'h1);
        report_test("receive");

        sent = {};
        repeat (uart_pkg::fifo_depth + 2) begin
            value = 8'($urandom());
            sent.push_back(value);
            send_frame(value, 1'b1);
        end
        check_read(uart_pkg::reg_rx_full, "rx_full", 32'h1);
        for (int i = 0; i < uart_pkg::fifo_depth; i++) begin
            check_read(uart_pkg::reg_rx_data, "rx_data", {24'h0, sent[i]});
        end
        check_read(uart_pkg::reg_rx_empty, "rx_empty", 32'h1);
        report_test("receive overflow");

        value = 8'($urandom());
        send_frame(value, 1'b0);
        hold_rx_idle();
        check_read(uart_pkg::reg_rx_empty, "rx_empty", 32'h1);
        value = 8'($urandom());
        send_frame(value, 1'b1);
        check_read(uart_pkg::reg_rx_data, "rx_data", {24'h0, value});
        check_read(uart_pkg::reg_rx_empty, "rx_empty", 32'h1);
        report_test("bad stop bit");

        $display("%0d tests run, %0d failed checks", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_periph.f */
source/uart_pkg.sv
source/byte_fifo.sv
source/uart_transmitter.sv
source/uart_receiver.sv
source/uart_periph.sv
testbench/uart_periph_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module uart_periph_tb \
		-f uart_periph.f -o uart_periph_sim
	@out="$$(./obj_dir/uart_periph_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
